// ==== flist.f ====
logic/streamer_pkg.sv
logic/load_fifo.sv
logic/addr_gen.sv
logic/stream_source.sv
logic/stream_sink.sv
logic/mem_arbiter.sv
logic/streamer_top.sv
tb/streamer_mem.sv
tb/streamer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= streamer_tb
FLIST     ?= flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test OK

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/streamer_tb.sv ====
/*
 * Streamer testbench
 * Runs strided loads and a strided store against a memory model with
 * random grant and ready, and compares every item with a reference.
 */
`timescale 1ns/1ps

module streamer_tb;
  import streamer_pkg::*;

  localparam int unsigned WORDS = 1024;
  localparam int unsigned IDX_W = $clog2(WORDS);

  // One row per run with columns X, W, Y and Z
  localparam addr_t RUN_BASE [3][4] = '{
    '{32'h0000_0000, 32'h0000_0100, 32'h0000_0300, 32'h0000_0C00},
    '{32'h0000_0040, 32'h0000_0200, 32'h0000_0380, 32'h0000_0D00},
    '{32'h0000_0400, 32'h0000_0600, 32'h0000_0700, 32'h0000_0E00}
  };
  localparam addr_t RUN_STRIDE [3][4] = '{
    '{32'd4, 32'd8, 32'd12, 32'd4},
    '{32'd4, 32'd4, 32'd4, 32'd4},
    '{32'd16, 32'd4, 32'd4, 32'd8}
  };
  localparam int RUN_LEN [3][4] = '{
    '{12, 10, 8, 9},
    '{16, 16, 16, 16},
    '{14, 11, 0, 10}
  };

  function automatic int sum_lengths();
    int s;
    s = 0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 4; c++) begin
        s += RUN_LEN[r][c];
      end
    end
    return s;
  endfunction

  localparam int LIMIT = 20 * sum_lengths() + 200;

  logic        clk;
  logic        reset;
  logic        clear;
  logic        start;
  logic        z_priority;
  addr_t       cfg_base [4];
  addr_t       cfg_stride [4];
  len_t        cfg_len [4];
  logic [2:0]  lv;
  logic [2:0]  lr;
  data_t       ld_data [3];
  logic        z_valid;
  logic        z_ready;
  data_t       z_data;
  logic [3:0]  done_v;
  logic        mem_req;
  addr_t       mem_addr;
  logic        mem_wen;
  data_t       mem_wdata;
  logic        mem_gnt;
  logic        mem_rvalid;
  data_t       mem_rdata;
  logic        rec_clear;
  data_t       image [WORDS];
  logic        wr_flag [WORDS];
  data_t       wr_data [WORDS];
  int unsigned wr_count;
  int unsigned rd_count;

  int          seed;
  int          errors;
  int          checks;
  int          cycles = 0;
  int          ld_idx [3];
  int          z_acc;
  int unsigned z_total;
  logic        z_run;
  logic        z_hold;
  logic        z_took;
  data_t       z_sent [$];

  streamer_top #(
    .FIFO_DEPTH ( 4 )
  ) dut0 (
    .clk_i (clk), .reset_i (reset), .clear_i (clear), .start_i (start),
    .z_priority_i (z_priority),
    .x_base_i (cfg_base[0]), .x_stride_i (cfg_stride[0]), .x_len_i (cfg_len[0]),
    .w_base_i (cfg_base[1]), .w_stride_i (cfg_stride[1]), .w_len_i (cfg_len[1]),
    .y_base_i (cfg_base[2]), .y_stride_i (cfg_stride[2]), .y_len_i (cfg_len[2]),
    .z_base_i (cfg_base[3]), .z_stride_i (cfg_stride[3]), .z_len_i (cfg_len[3]),
    .x_valid_o (lv[0]), .x_ready_i (lr[0]), .x_data_o (ld_data[0]),
    .w_valid_o (lv[1]), .w_ready_i (lr[1]), .w_data_o (ld_data[1]),
    .y_valid_o (lv[2]), .y_ready_i (lr[2]), .y_data_o (ld_data[2]),
    .z_valid_i (z_valid), .z_ready_o (z_ready), .z_data_i (z_data),
    .x_done_o (done_v[0]), .w_done_o (done_v[1]),
    .y_done_o (done_v[2]), .z_done_o (done_v[3]),
    .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_wen_o (mem_wen),
    .mem_wdata_o (mem_wdata), .mem_gnt_i (mem_gnt),
    .mem_rvalid_i (mem_rvalid), .mem_rdata_i (mem_rdata)
  );

  streamer_mem #(
    .WORDS ( WORDS )
  ) mem0 (
    .clk_i (clk), .reset_i (reset), .rec_clear_i (rec_clear), .image_i (image),
    .req_i (mem_req), .gnt_i (mem_gnt), .addr_i (mem_addr), .wen_i (mem_wen),
    .wdata_i (mem_wdata), .rvalid_o (mem_rvalid), .rdata_o (mem_rdata),
    .wr_flag_o (wr_flag), .wr_data_o (wr_data),
    .wr_count_o (wr_count), .rd_count_o (rd_count)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("Timeout: the done flags did not all rise within %0d cycles", LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  // Reference word for a byte address
  function automatic data_t mem_word(input addr_t a);
    data_t x;
    x = a ^ 32'h5EED_C0DE;
    return {x[24:0], x[31:25]};
  endfunction

  function automatic logic pick(input int pct);
    int r;
    r = $random(seed);
    return ({r} % 100) < pct;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Sample the streams at the falling edge
  task automatic observe();
    logic z_wants;
    if (start || clear) begin
      for (int c = 0; c < 3; c++) begin
        ld_idx[c] = 0;
      end
      z_acc = 0;
      z_sent.delete();
      z_run = !clear;
    end else begin
      for (int c = 0; c < 3; c++) begin
        if (done_v[c]) begin
          check(32'(lv[c]), 0, "load valid after done");
        end
        if (lv[c] && lr[c]) begin
          check(32'(ld_idx[c] < int'(cfg_len[c])), 1, "load item beyond length");
          check(ld_data[c], mem_word(cfg_base[c] + addr_t'(ld_idx[c]) * cfg_stride[c]),
                "load data");
          ld_idx[c]++;
        end
      end
      // Sink requests while its walk is open and an item is offered
      z_wants = z_run && (z_acc < int'(cfg_len[3])) && z_valid;
      if (z_priority && z_wants) begin
        check(32'({mem_req, mem_wen}), 32'd3, "read selected over a Z write");
      end
      if (z_valid && z_ready) begin
        z_sent.push_back(z_data);
        z_acc++;
        z_total++;
        z_took = 1'b1;
      end
      if (&done_v) begin
        check(32'(mem_req), 0, "memory request after all channels done");
      end
    end
  endtask

  task automatic drive();
    for (int c = 0; c < 3; c++) begin
      lr[c] = pick(60);
    end
    mem_gnt = pick(70);
    // Z keeps an offered item until it is taken
    if (z_hold) begin
      z_valid = 1'b1;
    end else if (!z_valid || z_took) begin
      z_valid = pick(60);
    end
    z_took = 1'b0;
    z_data = 32'h7E00_0000 + z_total;
  endtask

  task automatic step();
    @(negedge clk);
    observe();
    @(posedge clk);
    #2;
    drive();
  endtask

  task automatic check_idle(input string what);
    @(negedge clk);
    check(32'({lv, z_ready, mem_req, done_v}), 32'd0, what);
    @(posedge clk);
    #2;
  endtask

  task automatic load_config(input int r);
    for (int c = 0; c < 4; c++) begin
      cfg_base[c]   = RUN_BASE[r][c];
      cfg_stride[c] = RUN_STRIDE[r][c];
      cfg_len[c]    = len_t'(RUN_LEN[r][c]);
    end
  endtask

  task automatic start_run();
    start     = 1'b1;
    rec_clear = 1'b1;
    step();
    start     = 1'b0;
    rec_clear = 1'b0;
  endtask

  task automatic wait_done();
    while (done_v != 4'hF) begin
      step();
    end
    repeat (4) step();
  endtask

  task automatic check_results();
    addr_t       a;
    int unsigned reads;
    reads = 0;
    for (int c = 0; c < 3; c++) begin
      check(32'(ld_idx[c]), 32'(cfg_len[c]), "load item count");
      reads += 32'(cfg_len[c]);
    end
    check(rd_count, reads, "memory read count");
    check(32'(z_sent.size()), 32'(cfg_len[3]), "Z item count");
    check(wr_count, 32'(cfg_len[3]), "memory write count");
    for (int i = 0; i < z_sent.size(); i++) begin
      a = cfg_base[3] + addr_t'(i) * cfg_stride[3];
      check(32'(wr_flag[a[IDX_W+1:2]]), 1, "Z address written");
      check(wr_data[a[IDX_W+1:2]], z_sent[i], "Z stored word");
    end
  endtask

  initial begin
    seed       = 85;
    errors     = 0;
    checks     = 0;
    reset      = 1'b1;
    clear      = 1'b0;
    start      = 1'b0;
    z_priority = 1'b0;
    lr         = '0;
    z_valid    = 1'b0;
    z_data     = '0;
    mem_gnt    = 1'b0;
    rec_clear  = 1'b0;
    z_total    = 0;
    z_acc      = 0;
    z_run      = 1'b0;
    z_hold     = 1'b0;
    z_took     = 1'b0;
    for (int c = 0; c < 4; c++) begin
      cfg_base[c]   = '0;
      cfg_stride[c] = '0;
      cfg_len[c]    = '0;
    end
    for (int c = 0; c < 3; c++) begin
      ld_idx[c] = 0;
    end
    for (int i = 0; i < WORDS; i++) begin
      image[i] = mem_word(addr_t'(i) << 2);
    end

    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    check_idle("outputs not idle after reset");

    // Round robin with random Z stream
    load_config(0);
    start_run();
    wait_done();
    check_results();

    // Z priority run cleared once Z is done and the loads are busy
    load_config(1);
    z_priority = 1'b1;
    z_hold     = 1'b1;
    start_run();
    while (!done_v[3]) begin
      step();
    end
    repeat (8) step();
    clear = 1'b1;
    step();
    clear = 1'b0;
    check_idle("outputs not idle after clear");

    // Fresh bases after clear and no items for Y
    load_config(2);
    start_run();
    wait_done();
    check_results();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/streamer_mem.sv ====
/*
 * Streamer memory model
 * Word memory behind the request/grant port. A granted read returns
 * its word one cycle later. Granted writes go to a separate record.
 */
`timescale 1ns/1ps

module streamer_mem #(
  parameter int unsigned WORDS = 1024
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 rec_clear_i,
  input  streamer_pkg::data_t  image_i [WORDS],
  input  logic                 req_i,
  input  logic                 gnt_i,
  input  streamer_pkg::addr_t  addr_i,
  input  logic                 wen_i,
  input  streamer_pkg::data_t  wdata_i,
  output logic                 rvalid_o,
  output streamer_pkg::data_t  rdata_o,
  output logic                 wr_flag_o [WORDS],
  output streamer_pkg::data_t  wr_data_o [WORDS],
  output int unsigned          wr_count_o,
  output int unsigned          rd_count_o
);
  import streamer_pkg::*;

  localparam int unsigned IDX_W = $clog2(WORDS);

  logic [IDX_W-1:0] idx;
  logic             xfer;

  // Word index from the byte address
  assign idx  = addr_i[IDX_W+1:2];
  assign xfer = req_i && gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= xfer && !wen_i;
    end
    rdata_o <= image_i[idx];
  end

  // Write record and access counts
  always_ff @(posedge clk_i) begin
    if (reset_i || rec_clear_i) begin
      for (int i = 0; i < WORDS; i++) begin
        wr_flag_o[i] <= 1'b0;
      end
      wr_count_o <= 0;
      rd_count_o <= 0;
    end else if (xfer) begin
      if (wen_i) begin
        wr_flag_o[idx] <= 1'b1;
        wr_data_o[idx] <= wdata_i;
        wr_count_o     <= wr_count_o + 1;
      end else begin
        rd_count_o <= rd_count_o + 1;
      end
    end
  end

endmodule

// ==== logic/streamer_top.sv ====
/*
 * Streamer top
 * Three strided load channels (X, W, Y), one strided store channel (Z)
 * and the arbiter onto the shared memory port.
 */
`timescale 1ns/1ps

module streamer_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  logic                 z_priority_i,
  // Channel configuration
  input  streamer_pkg::addr_t  x_base_i,
  input  streamer_pkg::addr_t  x_stride_i,
  input  streamer_pkg::len_t   x_len_i,
  input  streamer_pkg::addr_t  w_base_i,
  input  streamer_pkg::addr_t  w_stride_i,
  input  streamer_pkg::len_t   w_len_i,
  input  streamer_pkg::addr_t  y_base_i,
  input  streamer_pkg::addr_t  y_stride_i,
  input  streamer_pkg::len_t   y_len_i,
  input  streamer_pkg::addr_t  z_base_i,
  input  streamer_pkg::addr_t  z_stride_i,
  input  streamer_pkg::len_t   z_len_i,
  // Load streams
  output logic                 x_valid_o,
  input  logic                 x_ready_i,
  output streamer_pkg::data_t  x_data_o,
  output logic                 w_valid_o,
  input  logic                 w_ready_i,
  output streamer_pkg::data_t  w_data_o,
  output logic                 y_valid_o,
  input  logic                 y_ready_i,
  output streamer_pkg::data_t  y_data_o,
  // Store stream
  input  logic                 z_valid_i,
  output logic                 z_ready_o,
  input  streamer_pkg::data_t  z_data_i,
  // Completion
  output logic                 x_done_o,
  output logic                 w_done_o,
  output logic                 y_done_o,
  output logic                 z_done_o,
  // Memory port
  output logic                 mem_req_o,
  output streamer_pkg::addr_t  mem_addr_o,
  output logic                 mem_wen_o,
  output streamer_pkg::data_t  mem_wdata_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  streamer_pkg::data_t  mem_rdata_i
);
  import streamer_pkg::*;

  localparam int unsigned NUM_LOAD = NUM_CHAN - 1;

  // Load channel index matches the arbiter index: X, W, Y
  addr_t [NUM_LOAD-1:0] ld_base;
  addr_t [NUM_LOAD-1:0] ld_stride;
  len_t  [NUM_LOAD-1:0] ld_len;
  logic  [NUM_LOAD-1:0] ld_ready;
  logic  [NUM_LOAD-1:0] ld_valid;
  data_t [NUM_LOAD-1:0] ld_data;
  logic  [NUM_LOAD-1:0] ld_done;

  logic  [NUM_CHAN-1:0] req;
  logic  [NUM_CHAN-1:0] gnt;
  addr_t [NUM_CHAN-1:0] addr;
  logic  [NUM_LOAD-1:0] resp_valid;
  data_t                resp_data;
  data_t                z_wdata;

  assign ld_base   = {y_base_i, w_base_i, x_base_i};
  assign ld_stride = {y_stride_i, w_stride_i, x_stride_i};
  assign ld_len    = {y_len_i, w_len_i, x_len_i};
  assign ld_ready  = {y_ready_i, w_ready_i, x_ready_i};

  for (genvar i = 0; i < NUM_LOAD; i++) begin : gen_source
    stream_source #(
      .FIFO_DEPTH ( FIFO_DEPTH )
    ) i_source (
      .clk_i        ( clk_i         ),
      .reset_i      ( reset_i       ),
      .clear_i      ( clear_i       ),
      .start_i      ( start_i       ),
      .base_i       ( ld_base[i]    ),
      .stride_i     ( ld_stride[i]  ),
      .len_i        ( ld_len[i]     ),
      .gnt_i        ( gnt[i]        ),
      .resp_valid_i ( resp_valid[i] ),
      .resp_data_i  ( resp_data     ),
      .ready_i      ( ld_ready[i]   ),
      .req_o        ( req[i]        ),
      .addr_o       ( addr[i]       ),
      .valid_o      ( ld_valid[i]   ),
      .data_o       ( ld_data[i]    ),
      .done_o       ( ld_done[i]    )
    );
  end

  stream_sink i_sink (
    .clk_i    ( clk_i        ),
    .reset_i  ( reset_i      ),
    .clear_i  ( clear_i      ),
    .start_i  ( start_i      ),
    .base_i   ( z_base_i     ),
    .stride_i ( z_stride_i   ),
    .len_i    ( z_len_i      ),
    .gnt_i    ( gnt[CHAN_Z]  ),
    .valid_i  ( z_valid_i    ),
    .data_i   ( z_data_i     ),
    .req_o    ( req[CHAN_Z]  ),
    .addr_o   ( addr[CHAN_Z] ),
    .wdata_o  ( z_wdata      ),
    .ready_o  ( z_ready_o    ),
    .done_o   ( z_done_o     )
  );

  mem_arbiter i_arbiter (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .clear_i      ( clear_i      ),
    .z_priority_i ( z_priority_i ),
    .req_i        ( req          ),
    .addr_i       ( addr         ),
    .wdata_i      ( z_wdata      ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_rdata_i  ( mem_rdata_i  ),
    .gnt_o        ( gnt          ),
    .resp_valid_o ( resp_valid   ),
    .resp_data_o  ( resp_data    ),
    .mem_req_o    ( mem_req_o    ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wen_o    ( mem_wen_o    ),
    .mem_wdata_o  ( mem_wdata_o  )
  );

  assign x_valid_o = ld_valid[0];
  assign x_data_o  = ld_data[0];
  assign x_done_o  = ld_done[0];
  assign w_valid_o = ld_valid[1];
  assign w_data_o  = ld_data[1];
  assign w_done_o  = ld_done[1];
  assign y_valid_o = ld_valid[2];
  assign y_data_o  = ld_data[2];
  assign y_done_o  = ld_done[2];

endmodule

// ==== logic/mem_arbiter.sv ====
/*
 * Memory arbiter
 * Merges the channel requests onto the shared memory port with Z
 * priority or round robin, and steers in-order read responses back.
 */
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          clear_i,
  input  logic                                          z_priority_i,
  input  logic [streamer_pkg::NUM_CHAN-1:0]             req_i,
  input  streamer_pkg::addr_t [streamer_pkg::NUM_CHAN-1:0] addr_i,
  input  streamer_pkg::data_t                           wdata_i,
  input  logic                                          mem_gnt_i,
  input  logic                                          mem_rvalid_i,
  input  streamer_pkg::data_t                           mem_rdata_i,
  output logic [streamer_pkg::NUM_CHAN-1:0]             gnt_o,
  output logic [streamer_pkg::NUM_CHAN-2:0]             resp_valid_o,
  output streamer_pkg::data_t                           resp_data_o,
  output logic                                          mem_req_o,
  output streamer_pkg::addr_t                           mem_addr_o,
  output logic                                          mem_wen_o,
  output streamer_pkg::data_t                           mem_wdata_o
);
  import streamer_pkg::*;

  chan_t last_q;
  chan_t sel;
  logic  granted;
  logic  rd_pend_q;

  // Round robin starting after the last granted channel
  always_comb begin
    chan_t cand;
    logic  found;
    sel   = last_q;
    found = 1'b0;
    for (int i = 1; i <= NUM_CHAN; i++) begin
      cand = chan_t'((int'(last_q) + i) % NUM_CHAN);
      if (!found && req_i[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
    // Store channel overrides the rotation
    if (z_priority_i && req_i[CHAN_Z]) begin
      sel = CHAN_Z;
    end
  end

  assign mem_req_o   = |req_i;
  assign mem_addr_o  = addr_i[sel];
  assign mem_wen_o   = (sel == CHAN_Z);
  assign mem_wdata_o = wdata_i;
  assign granted     = mem_req_o && mem_gnt_i;

  always_comb begin
    for (int i = 0; i < NUM_CHAN; i++) begin
      gnt_o[i] = granted && (sel == chan_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      last_q    <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= granted && !mem_wen_o;
      if (granted) begin
        last_q <= sel;
      end
    end
  end

  // Response arrives one cycle after the read grant
  // The last granted channel is the owner of that read
  always_comb begin
    for (int i = 0; i < NUM_CHAN - 1; i++) begin
      resp_valid_o[i] = mem_rvalid_i && rd_pend_q && (last_q == chan_t'(i));
    end
  end

  assign resp_data_o = mem_rdata_i;

endmodule

// ==== logic/stream_sink.sv ====
/*
 * Stream sink
 * Store channel: writes each incoming stream item to the next
 * strided address. The memory grant also accepts the item.
 */
`timescale 1ns/1ps

module stream_sink (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  streamer_pkg::addr_t  base_i,
  input  streamer_pkg::addr_t  stride_i,
  input  streamer_pkg::len_t   len_i,
  input  logic                 gnt_i,
  input  logic                 valid_i,
  input  streamer_pkg::data_t  data_i,
  output logic                 req_o,
  output streamer_pkg::addr_t  addr_o,
  output streamer_pkg::data_t  wdata_o,
  output logic                 ready_o,
  output logic                 done_o
);

  logic agen_active;
  logic accept;

  addr_gen i_addr_gen (
    .clk_i    ( clk_i       ),
    .reset_i  ( reset_i     ),
    .clear_i  ( clear_i     ),
    .start_i  ( start_i     ),
    .base_i   ( base_i      ),
    .stride_i ( stride_i    ),
    .len_i    ( len_i       ),
    .next_i   ( accept      ),
    .addr_o   ( addr_o      ),
    .active_o ( agen_active ),
    .last_o   (             ),
    .done_o   ( done_o      )
  );

  // Request only with an address pending and an item on the stream
  assign req_o   = agen_active && valid_i;
  assign wdata_o = data_i;

  // Stream handshake coincides with the write grant
  assign accept  = req_o && gnt_i;
  assign ready_o = accept;

endmodule

// ==== logic/stream_source.sv ====
/*
 * Stream source
 * Load channel: issues strided reads while FIFO credit remains and
 * presents the returned words as a valid/ready stream.
 */
`timescale 1ns/1ps

module stream_source #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  streamer_pkg::addr_t  base_i,
  input  streamer_pkg::addr_t  stride_i,
  input  streamer_pkg::len_t   len_i,
  input  logic                 gnt_i,
  input  logic                 resp_valid_i,
  input  streamer_pkg::data_t  resp_data_i,
  input  logic                 ready_i,
  output logic                 req_o,
  output streamer_pkg::addr_t  addr_o,
  output logic                 valid_o,
  output streamer_pkg::data_t  data_o,
  output logic                 done_o
);
  import streamer_pkg::*;

  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic             agen_active;
  logic             agen_done;
  logic [CNT_W-1:0] out_cnt_q;
  logic [CNT_W-1:0] fifo_count;
  logic [CNT_W:0]   credit_used;
  logic             fifo_empty;
  logic             issue;
  logic             pop;
  len_t             len_q;
  len_t             deliv_q;

  addr_gen i_addr_gen (
    .clk_i    ( clk_i       ),
    .reset_i  ( reset_i     ),
    .clear_i  ( clear_i     ),
    .start_i  ( start_i     ),
    .base_i   ( base_i      ),
    .stride_i ( stride_i    ),
    .len_i    ( len_i       ),
    .next_i   ( issue       ),
    .addr_o   ( addr_o      ),
    .active_o ( agen_active ),
    .last_o   (             ),
    .done_o   ( agen_done   )
  );

  // Words in flight plus words buffered never exceed the FIFO depth
  assign credit_used = {1'b0, out_cnt_q} + {1'b0, fifo_count};
  assign req_o       = agen_active && (credit_used < (CNT_W+1)'(FIFO_DEPTH));
  assign issue       = req_o && gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      out_cnt_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_q + CNT_W'(issue) - CNT_W'(resp_valid_i);
    end
  end

  load_fifo #(
    .DEPTH ( FIFO_DEPTH )
  ) i_load_fifo (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .clear_i ( clear_i      ),
    .push_i  ( resp_valid_i ),
    .data_i  ( resp_data_i  ),
    .pop_i   ( pop          ),
    .data_o  ( data_o       ),
    .empty_o ( fifo_empty   ),
    .count_o ( fifo_count   )
  );

  assign valid_o = !fifo_empty;
  assign pop     = valid_o && ready_i;

  // Items handed to the consumer since start
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      len_q   <= '0;
      deliv_q <= '0;
    end else if (start_i) begin
      len_q   <= len_i;
      deliv_q <= '0;
    end else if (pop) begin
      deliv_q <= deliv_q + 1'b1;
    end
  end

  // All reads issued and every returned word delivered
  assign done_o = agen_done && (deliv_q == len_q);

endmodule

// ==== logic/addr_gen.sv ====
/*
 * Address generator
 * Walks base plus multiples of stride for len items and
 * flags the end of the walk.
 */
`timescale 1ns/1ps

module addr_gen (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  streamer_pkg::addr_t  base_i,
  input  streamer_pkg::addr_t  stride_i,
  input  streamer_pkg::len_t   len_i,
  input  logic                 next_i,
  output streamer_pkg::addr_t  addr_o,
  output logic                 active_o,
  output logic                 last_o,
  output logic                 done_o
);
  import streamer_pkg::*;

  agen_state_e state_q;
  addr_t       addr_q;
  addr_t       stride_q;
  len_t        len_q;
  len_t        cnt_q;

  assign active_o = (state_q == RUN);
  assign last_o   = active_o && (cnt_q == len_q - 1'b1);
  assign done_o   = (state_q == DONE);
  assign addr_o   = addr_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if (start_i) begin
      // Zero length finishes at once
      state_q <= (len_i == '0) ? DONE : RUN;
      cnt_q   <= '0;
    end else if (active_o && next_i) begin
      cnt_q <= cnt_q + 1'b1;
      if (last_o) begin
        state_q <= DONE;
      end
    end
  end

  // Walk configuration and current address
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
      len_q    <= len_i;
    end else if (active_o && next_i) begin
      addr_q <= addr_q + stride_q;
    end
  end

endmodule

// ==== logic/load_fifo.sv ====
/*
 * Load FIFO
 * Circular buffer for the read responses of one load channel.
 * The head word is always presented on data_o.
 */
`timescale 1ns/1ps

module load_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         clear_i,
  input  logic                         push_i,
  input  streamer_pkg::data_t          data_i,
  input  logic                         pop_i,
  output streamer_pkg::data_t          data_o,
  output logic                         empty_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);
  import streamer_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  data_t             mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_push;
  logic              do_pop;

  // The source never pushes beyond its credit, full is only a safety net
  assign do_push = push_i && (count_q != CNT_W'(DEPTH));
  assign do_pop  = pop_i && (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

endmodule

// ==== logic/streamer_pkg.sv ====
/*
 * Streamer package
 * Word, address and length widths, the vector types built on them,
 * the channel index type and the address generator states.
 */
package streamer_pkg;

  // Memory word and stream item width
  localparam int unsigned DATA_W = 32;

  // Byte address width
  localparam int unsigned ADDR_W = 32;

  // Item count width
  localparam int unsigned LEN_W = 16;

  // Number of memory requesters: X, W and Y loads plus the Z store
  localparam int unsigned NUM_CHAN = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;

  // Arbiter channel index, 0 is X, 1 is W, 2 is Y, 3 is Z
  typedef logic [1:0] chan_t;

  // The store channel, the only one that writes
  localparam chan_t CHAN_Z = 2'd3;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } agen_state_e;

endpackage
